// ==== hw/arcade_ctrl_pkg.sv ====
// Shared constants for the player input and control block
// Joystick words are active low, a released button reads as 1
// Step tables assume the external shift register order of the
// two-player adapter and a 26-step load and shift frame
// PS/2 codes are scan code set 2 as sent by a standard keyboard

package arcade_ctrl_pkg;

  // ----------------------------------------
  // Joystick word and frame
  // ----------------------------------------
  localparam int JOY_W       = 12;            // Bits per joystick word
  localparam int FRAME_STEPS = 26;            // Load step plus 25 shift steps
  localparam int STEP_W      = $clog2(FRAME_STEPS);

  typedef logic [STEP_W-1:0] step_t;

  // Word layout
  // [5:0] directions and fire, [7] spare, [8] start
  // [9] coin, [10] spare, [11] reset

  // Frame step at which each bit is sampled, indexed by bit number
  localparam step_t JOY1_STEP [JOY_W] = '{
    step_t'(9),  step_t'(8),  step_t'(7),  step_t'(6),    // Bits 0 to 3
    step_t'(5),  step_t'(4),  step_t'(3),  step_t'(25),   // Bits 4 to 7
    step_t'(2),  step_t'(24), step_t'(22), step_t'(23)    // Bits 8 to 11
  };

  localparam step_t JOY2_STEP [JOY_W] = '{
    step_t'(17), step_t'(16), step_t'(15), step_t'(14),   // Bits 0 to 3
    step_t'(13), step_t'(12), step_t'(11), step_t'(21),   // Bits 4 to 7
    step_t'(10), step_t'(20), step_t'(18), step_t'(19)    // Bits 8 to 11
  };

  // ----------------------------------------
  // PS/2 hot keys
  // ----------------------------------------
  localparam logic [7:0] KEY_BREAK = 8'hF0;   // Break prefix
  localparam logic [7:0] KEY_EXT   = 8'hE0;   // Extended prefix

  localparam logic [7:0] KEY_RESET = 8'h07;   // F12
  localparam logic [7:0] KEY_CTRL  = 8'h14;   // Left or right Ctrl
  localparam logic [7:0] KEY_ALT   = 8'h11;   // Left Alt or AltGr
  localparam logic [7:0] KEY_BKSP  = 8'h66;   // Backspace
  localparam logic [7:0] KEY_SCRL  = 8'h7E;   // Scroll Lock
  localparam logic [7:0] KEY_VMODE = 8'h06;   // F2

endpackage

// ==== hw/joy_serial_reader.sv ====
// Reads two joysticks through an external parallel-in shift register
// The register shares ena_x as its shift clock and loads while joy_load is low
// joy1 and joy2 only change at frame end, together with joy_valid
// Bit positions follow the step tables of arcade_ctrl_pkg

`timescale 1ns/1ns

module joy_serial_reader (
  input  logic                            ena_x,
  input  logic                            pll_lckd,
  input  logic                            joy_data,
  output logic                            joy_load,
  output logic [arcade_ctrl_pkg::JOY_W-1:0] joy1,
  output logic [arcade_ctrl_pkg::JOY_W-1:0] joy2,
  output logic                            joy_valid
);

  localparam int JW = arcade_ctrl_pkg::JOY_W;

  arcade_ctrl_pkg::step_t step;         // Current frame step
  logic                   last_step;

  logic [JW-1:0] shadow1, shadow2;      // Words being assembled
  logic [JW-1:0] next1, next2;          // Shadow words with this cycle's bit

  assign last_step = (step == arcade_ctrl_pkg::step_t'(arcade_ctrl_pkg::FRAME_STEPS - 1));

  // Parallel load happens only in step 0
  assign joy_load = (step != '0);

  // ----------------------------------------
  // Step counter
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      step <= '0;
    end else if (last_step) begin
      step <= '0;
    end else begin
      step <= step + 1'b1;
    end
  end

  // ----------------------------------------
  // Step indexed demultiplexer
  // ----------------------------------------
  always_comb begin
    next1 = shadow1;
    next2 = shadow2;
    for (int i = 0; i < JW; i++) begin
      if (step == arcade_ctrl_pkg::JOY1_STEP[i]) begin
        next1[i] = joy_data;
      end
      if (step == arcade_ctrl_pkg::JOY2_STEP[i]) begin
        next2[i] = joy_data;
      end
    end
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      shadow1 <= '1;                    // Released
      shadow2 <= '1;
    end else begin
      shadow1 <= next1;
      shadow2 <= next2;
    end
  end

  // ----------------------------------------
  // Publish at frame end
  // ----------------------------------------
  // Last bit of joy1 arrives in step 25, so the merged word is taken
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy1      <= '1;                  // All buttons released
      joy2      <= '1;
      joy_valid <= 1'b0;
    end else begin
      joy_valid <= last_step;
      if (last_step) begin
        joy1 <= next1;
        joy2 <= next2;
      end
    end
  end

endmodule

// ==== hw/ps2_receiver.sv ====
// PS/2 device to host receiver
// Lines are taken through two flip-flops, bits are taken on falling clock edges
// Frame is start 0, eight data bits LSB first, odd parity, stop 1
// Bad parity or stop bit drops the frame without a strobe
// A partial frame is dropped after PS2_TIMEOUT cycles with no clock edge
// ena_x must run well above the PS/2 clock rate

`timescale 1ns/1ns

module ps2_receiver #(
  parameter int PS2_TIMEOUT = 2000
) (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] scan_code,
  output logic       scan_valid
);

  localparam int TO_W = $clog2(PS2_TIMEOUT + 1);

  logic [1:0]      clk_sync;           // Two stage synchronizers
  logic [1:0]      data_sync;
  logic            clk_prev;
  logic            fall;

  logic [9:0]      shreg;              // Start, data and parity bits
  logic [10:0]     frame;              // Complete word with the stop bit
  logic            frame_ok;
  logic [3:0]      bit_cnt;
  logic [TO_W-1:0] idle_cnt;

  // ----------------------------------------
  // Synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;              // Bus idles high
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign fall = clk_prev & ~clk_sync[1];

  // Stop bit is still on the line when the last edge comes
  assign frame    = {data_sync[1], shreg};
  assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);   // Odd parity over data and parity

  // ----------------------------------------
  // Bit counter and idle timeout
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      scan_valid <= 1'b0;
    end else begin
      scan_valid <= 1'b0;
      if (fall) begin
        idle_cnt <= '0;
        if (bit_cnt == 4'd10) begin
          bit_cnt    <= '0;
          scan_valid <= frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (bit_cnt != '0) begin
        if (idle_cnt == TO_W'(PS2_TIMEOUT - 1)) begin
          bit_cnt  <= '0;              // Stuck frame, start over
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Shift register and code output
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      shreg     <= '0;
      scan_code <= '0;
    end else if (fall) begin
      shreg <= {data_sync[1], shreg[9:1]};     // LSB arrives first
      if (bit_cnt == 4'd10) begin
        scan_code <= frame[8:1];
      end
    end
  end

endmodule

// ==== hw/key_mapper.sv ====
// Turns PS/2 scan codes into hot key states
// F12 gives the reset key, Ctrl Alt Backspace gives the master reset
// Scroll Lock toggles the key mode and F2 toggles the video mode
// Toggles act on the first make only, typematic repeats are ignored
// Only Ctrl and Alt are accepted with the E0 prefix

`timescale 1ns/1ns

module key_mapper (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic [7:0] scan_code,
  input  logic       scan_valid,
  input  logic [1:0] scandbl_ctrl,
  output logic       reset_key,
  output logic       master_reset,
  output logic [1:0] led
);

  logic break_f;                       // Last code was F0
  logic ext_f;                         // Last code was E0
  logic make;

  // Held state of each hot key
  logic held_f12, held_ctrl, held_alt, held_bksp, held_scrl, held_f2;

  logic key_mode;
  logic video_toggle;

  assign make = ~break_f;

  // ----------------------------------------
  // Prefix flags and key tracking
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      break_f      <= 1'b0;
      ext_f        <= 1'b0;
      held_f12     <= 1'b0;
      held_ctrl    <= 1'b0;
      held_alt     <= 1'b0;
      held_bksp    <= 1'b0;
      held_scrl    <= 1'b0;
      held_f2      <= 1'b0;
      key_mode     <= 1'b0;
      video_toggle <= 1'b0;
    end else if (scan_valid) begin
      if (scan_code == arcade_ctrl_pkg::KEY_BREAK) begin
        break_f <= 1'b1;
      end else if (scan_code == arcade_ctrl_pkg::KEY_EXT) begin
        ext_f <= 1'b1;
      end else begin
        break_f <= 1'b0;               // Prefixes apply to one code only
        ext_f   <= 1'b0;
        case (scan_code)
          arcade_ctrl_pkg::KEY_RESET: if (!ext_f) held_f12 <= make;
          arcade_ctrl_pkg::KEY_CTRL:  held_ctrl <= make;     // Left or right
          arcade_ctrl_pkg::KEY_ALT:   held_alt  <= make;
          arcade_ctrl_pkg::KEY_BKSP:  if (!ext_f) held_bksp <= make;
          arcade_ctrl_pkg::KEY_SCRL: begin
            // E0 7E comes from Ctrl+Break
            if (!ext_f) begin
              held_scrl <= make;
              if (make && !held_scrl) key_mode <= ~key_mode;
            end
          end
          arcade_ctrl_pkg::KEY_VMODE: begin
            if (!ext_f) begin
              held_f2 <= make;
              if (make && !held_f2) video_toggle <= ~video_toggle;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign reset_key    = held_f12;
  assign master_reset = held_ctrl & held_alt & held_bksp;

  assign led[0] = key_mode;
  assign led[1] = scandbl_ctrl[0] ^ video_toggle;     // Lit in the other video mode

endmodule

// ==== hw/panel_ctrl.sv ====
// Board buttons and joystick words to arcade core inputs
// Buttons are active low and asynchronous to ena_x
// core_reset stays high for RST_HOLD cycles after the last reset cause
// RST_HOLD must be at least 1
// reboot is a single cycle pulse for the multiboot logic

`timescale 1ns/1ns

module panel_ctrl #(
  parameter int RST_HOLD = 64
) (
  input  logic                              ena_x,
  input  logic                              pll_lckd,
  input  logic [1:0]                        btn,
  input  logic [arcade_ctrl_pkg::JOY_W-1:0] joy1,
  input  logic [arcade_ctrl_pkg::JOY_W-1:0] joy2,
  input  logic                              reset_key,
  input  logic                              master_reset,
  output logic [5:0]                        joy_a,
  output logic [5:0]                        joy_b,
  output logic [1:0]                        coin,
  output logic [1:0]                        player,
  output logic                              core_reset,
  output logic                              reboot
);

  localparam int HOLD_W = $clog2(RST_HOLD + 1);

  logic [1:0]        btn_meta, btn_sync;
  logic              rst_cause;
  logic [HOLD_W-1:0] hold_cnt;          // Cycles since the cause ended
  logic              reboot_req;
  logic              reboot_req_q;

  // ----------------------------------------
  // Button synchronizer
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      btn_meta <= 2'b11;               // Released
      btn_sync <= 2'b11;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  // ----------------------------------------
  // Core reset stretch
  // ----------------------------------------
  assign rst_cause = reset_key | ~joy1[11] | ~btn_sync[1];

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      core_reset <= 1'b1;              // Core starts in reset
      hold_cnt   <= '0;
    end else if (rst_cause) begin
      core_reset <= 1'b1;
      hold_cnt   <= '0;
    end else if (core_reset) begin
      if (hold_cnt == HOLD_W'(RST_HOLD - 1)) begin
        core_reset <= 1'b0;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Reboot pulse on request rise
  // ----------------------------------------
  assign reboot_req = master_reset | ~joy2[11];

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      reboot_req_q <= 1'b0;
      reboot       <= 1'b0;
    end else begin
      reboot_req_q <= reboot_req;
      reboot       <= reboot_req & ~reboot_req_q;
    end
  end

  // Core inputs straight from the published words
  assign joy_a  = joy1[5:0];
  assign joy_b  = joy2[5:0];
  assign coin   = {joy2[9], joy1[9] & btn_sync[0]};   // btn[0] doubles as coin 1
  assign player = {joy2[8], joy1[8]};

endmodule

// ==== hw/arcade_ctrl_top.sv ====
// Player input and control block of the arcade port
// ena_x also clocks the external joystick shift register, that
// clock output is made outside this block
// scandbl_ctrl comes from the scan doubler setting read elsewhere
// All outputs are registered or combinational from registers

`timescale 1ns/1ns

module arcade_ctrl_top #(
  parameter int RST_HOLD    = 64,
  parameter int PS2_TIMEOUT = 2000
) (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       joy_data,
  output logic       joy_load,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic [1:0] btn,
  input  logic [1:0] scandbl_ctrl,
  output logic [5:0] joy_a,
  output logic [5:0] joy_b,
  output logic [1:0] coin,
  output logic [1:0] player,
  output logic       core_reset,
  output logic       reboot,
  output logic [1:0] led
);

  logic [arcade_ctrl_pkg::JOY_W-1:0] joy1, joy2;
  logic                              joy_valid;   // Frame marker, unused by the core
  logic [7:0]                        scan_code;
  logic                              scan_valid;
  logic                              reset_key;
  logic                              master_reset;

  // ----------------------------------------
  // Input paths
  // ----------------------------------------
  joy_serial_reader u_joy (
    .ena_x     (ena_x),
    .pll_lckd  (pll_lckd),
    .joy_data  (joy_data),
    .joy_load  (joy_load),
    .joy1      (joy1),
    .joy2      (joy2),
    .joy_valid (joy_valid)
  );

  ps2_receiver #(.PS2_TIMEOUT(PS2_TIMEOUT)) u_ps2 (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .scan_valid (scan_valid)
  );

  key_mapper u_keys (
    .ena_x        (ena_x),
    .pll_lckd     (pll_lckd),
    .scan_code    (scan_code),
    .scan_valid   (scan_valid),
    .scandbl_ctrl (scandbl_ctrl),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .led          (led)
  );

  // ----------------------------------------
  // Core side
  // ----------------------------------------
  panel_ctrl #(.RST_HOLD(RST_HOLD)) u_panel (
    .ena_x        (ena_x),
    .pll_lckd     (pll_lckd),
    .btn          (btn),
    .joy1         (joy1),
    .joy2         (joy2),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .joy_a        (joy_a),
    .joy_b        (joy_b),
    .coin         (coin),
    .player       (player),
    .core_reset   (core_reset),
    .reboot       (reboot)
  );

endmodule

// ==== sim/arcade_ctrl_sva.sv ====
// Assertions for the player input and control block, bound into arcade_ctrl_top
// Small reference models rebuild the expected outputs from the frame, key and reset rules
// All checks are sampled on ena_x and are off while pll_lckd is low
// fail_cnt counts failed checks for the testbench summary

`timescale 1ns/1ns

module arcade_ctrl_sva #(
  parameter int RST_HOLD = 64
) (
  input logic       ena_x,
  input logic       pll_lckd,
  input logic       joy_data,
  input logic       joy_load,
  input logic       ps2_clk,
  input logic       ps2_data,
  input logic [1:0] btn,
  input logic [1:0] scandbl_ctrl,
  input logic [7:0] scan_code,
  input logic       scan_valid,
  input logic       reset_key,
  input logic       master_reset,
  input logic [5:0] joy_a,
  input logic [5:0] joy_b,
  input logic [1:0] coin,
  input logic [1:0] player,
  input logic       core_reset,
  input logic       reboot,
  input logic [1:0] led
);

  localparam int JW = arcade_ctrl_pkg::JOY_W;

  int            fail_cnt = 0;
  logic [4:0]    step;                 // Expected frame step
  logic [25:0]   stream;               // Line value seen in each step
  logic [JW-1:0] w1, w2;               // Expected published words
  logic [1:0]    bs_m, bs;
  int            hold_left;            // Cycles core_reset must still be high
  logic          rq, rqq;
  logic          brk, ext, f12, ctl, alt, bks, scr, f2, mode, vt;
  logic          pc_q, pend;
  logic [10:0]   sr, frm;
  logic [3:0]    bitn;
  int            age;
  logic [7:0]    code;
  logic          cause, req;

  assign cause = f12 | ~w1[11] | ~bs[1];
  assign req   = (ctl & alt & bks) | ~w2[11];
  assign frm   = {ps2_data, sr[10:1]};

  always_ff @(posedge ena_x) begin
    stream[step] <= joy_data;
  end

  // ----------------------------------------
  // Reference models
  // ----------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      step      <= 5'd0;
      w1        <= '1;
      w2        <= '1;
      bs_m      <= 2'b11;
      bs        <= 2'b11;
      hold_left <= RST_HOLD;
      rq        <= 1'b0;
      rqq       <= 1'b0;
      {brk, ext, f12, ctl, alt, bks, scr, f2, mode, vt} <= '0;
      pc_q      <= 1'b1;
      pend      <= 1'b0;
      sr        <= '0;
      bitn      <= 4'd0;
      age       <= 0;
      code      <= 8'h00;
    end else begin
      step <= (step == 5'd25) ? 5'd0 : step + 5'd1;
      if (step == 5'd25) begin
        for (int i = 0; i < JW; i++) begin
          w1[i] <= (arcade_ctrl_pkg::JOY1_STEP[i] == 5'd25) ? joy_data
                                                           : stream[arcade_ctrl_pkg::JOY1_STEP[i]];
          w2[i] <= stream[arcade_ctrl_pkg::JOY2_STEP[i]];   // Joystick 2 ends at step 21
        end
      end
      bs_m <= btn;
      bs   <= bs_m;
      if (cause) begin
        hold_left <= RST_HOLD;
      end else if (hold_left != 0) begin
        hold_left <= hold_left - 1;
      end
      rq  <= req;
      rqq <= rq;
      // Hot keys
      if (scan_valid) begin
        if (scan_code == arcade_ctrl_pkg::KEY_BREAK) begin
          brk <= 1'b1;
        end else if (scan_code == arcade_ctrl_pkg::KEY_EXT) begin
          ext <= 1'b1;
        end else begin
          brk <= 1'b0;
          ext <= 1'b0;
          if (scan_code == arcade_ctrl_pkg::KEY_RESET && !ext) f12 <= !brk;
          if (scan_code == arcade_ctrl_pkg::KEY_CTRL) ctl <= !brk;
          if (scan_code == arcade_ctrl_pkg::KEY_ALT) alt <= !brk;
          if (scan_code == arcade_ctrl_pkg::KEY_BKSP && !ext) bks <= !brk;
          if (scan_code == arcade_ctrl_pkg::KEY_SCRL && !ext) begin
            scr <= !brk;
            if (!brk && !scr) mode <= ~mode;
          end
          if (scan_code == arcade_ctrl_pkg::KEY_VMODE && !ext) begin
            f2 <= !brk;
            if (!brk && !f2) vt <= ~vt;
          end
        end
      end
      // Raw PS/2 line decoder
      pc_q <= ps2_clk;
      if (pc_q && !ps2_clk) begin
        sr   <= frm;
        bitn <= (bitn == 4'd10) ? 4'd0 : bitn + 4'd1;
        if (bitn == 4'd10) begin
          code <= frm[8:1];
          pend <= !frm[0] && frm[10] && (^frm[9:1]);
          age  <= 0;
        end
      end else if (scan_valid) begin
        pend <= 1'b0;
      end else if (pend) begin
        age <= age + 1;
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_init: assert property (@(posedge ena_x) $rose(pll_lckd) |-> core_reset && !reboot)
    else begin
      fail_cnt++;
      $error("core_reset low or reboot high right after reset");
    end

  a_load: assert property (@(posedge ena_x) disable iff (!pll_lckd) joy_load == (step != 5'd0))
    else begin
      fail_cnt++;
      $error("ERROR joy_load %h in step %h", $sampled(joy_load), $sampled(step));
    end

  a_map: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    {joy_a, joy_b, player, coin} == {w1[5:0], w2[5:0], w2[8], w1[8], w2[9], w1[9] & bs[0]})
    else begin
      fail_cnt++;
      $error("ERROR joy_a,joy_b,player,coin %h expected %h",
             $sampled({joy_a, joy_b, player, coin}),
             $sampled({w1[5:0], w2[5:0], w2[8], w1[8], w2[9], w1[9] & bs[0]}));
    end

  a_reset: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    core_reset == (hold_left != 0))
    else begin
      fail_cnt++;
      $error("ERROR core_reset %h expected %h", $sampled(core_reset), $sampled(hold_left != 0));
    end

  a_reboot: assert property (@(posedge ena_x) disable iff (!pll_lckd) reboot == (rq && !rqq))
    else begin
      fail_cnt++;
      $error("ERROR reboot %h expected %h", $sampled(reboot), $sampled(rq && !rqq));
    end

  a_keys: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    {reset_key, master_reset} == {f12, ctl & alt & bks})
    else begin
      fail_cnt++;
      $error("ERROR reset_key,master_reset %h expected %h",
             $sampled({reset_key, master_reset}), $sampled({f12, ctl & alt & bks}));
    end

  a_led: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    led == {scandbl_ctrl[0] ^ vt, mode})
    else begin
      fail_cnt++;
      $error("ERROR led %h expected %h", $sampled(led), $sampled({scandbl_ctrl[0] ^ vt, mode}));
    end

  a_scan: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    scan_valid |-> pend && scan_code == code)
    else begin
      fail_cnt++;
      $error("ERROR scan_code %h expected %h pending %h",
             $sampled(scan_code), $sampled(code), $sampled(pend));
    end

  // Strobe at most four cycles after the stop bit edge on the raw line
  a_scan_late: assert property (@(posedge ena_x) disable iff (!pll_lckd) pend |-> age < 4)
    else begin
      fail_cnt++;
      $error("good PS/2 frame gave no scan_valid strobe in time");
    end

endmodule

bind arcade_ctrl_top arcade_ctrl_sva #(.RST_HOLD(RST_HOLD)) sva (
  .ena_x(ena_x), .pll_lckd(pll_lckd), .joy_data(joy_data), .joy_load(joy_load),
  .ps2_clk(ps2_clk), .ps2_data(ps2_data), .btn(btn), .scandbl_ctrl(scandbl_ctrl),
  .scan_code(scan_code), .scan_valid(scan_valid), .reset_key(reset_key),
  .master_reset(master_reset), .joy_a(joy_a), .joy_b(joy_b), .coin(coin),
  .player(player), .core_reset(core_reset), .reboot(reboot), .led(led)
);

// ==== sim/tb_arcade_ctrl.sv ====
// Testbench for the player input and control block
// Checking is done by the bound assertion module, this sequence drives the cases
// Joystick model follows joy_load, PS/2 model uses four cycles per half period

`timescale 1ns/1ns

module tb_arcade_ctrl;

  localparam int HOLD    = 16;
  localparam int WAIT_TO = 400;        // Cycle limit of every wait
  localparam int J1R = int'(arcade_ctrl_pkg::JOY1_STEP[11]) - 2;
  localparam int J2R = int'(arcade_ctrl_pkg::JOY2_STEP[11]) - 2;

  logic        ena_x, pll_lckd, ps2_clk, ps2_data;
  logic        joy_data = 1'b1;
  logic [1:0]  btn, scandbl_ctrl;
  logic        joy_load, core_reset, reboot;
  logic [5:0]  joy_a, joy_b;
  logic [1:0]  coin, player, led;

  logic [23:0] joy_pat;                // Line values of steps 2 to 25
  int          tstep = 0;
  int          seed;
  int          wait_errs = 0;
  int          n_tests = 0;
  int          n_bad = 0;
  int          last_fails = 0;

  arcade_ctrl_top #(.RST_HOLD(HOLD)) uut (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .joy_data(joy_data), .joy_load(joy_load),
    .ps2_clk(ps2_clk), .ps2_data(ps2_data), .btn(btn), .scandbl_ctrl(scandbl_ctrl),
    .joy_a(joy_a), .joy_b(joy_b), .coin(coin), .player(player),
    .core_reset(core_reset), .reboot(reboot), .led(led)
  );

  initial begin
    ena_x = 1'b0;
    forever #4 ena_x = ~ena_x;
  end

  // ----------------------------------------
  // Joystick shift register model
  // ----------------------------------------
  function automatic logic stream_bit(input int s);
    if (s < 2 || s > 25) return 1'b1;  // Steps 0 and 1 carry no button
    return joy_pat[5'(s - 2)];
  endfunction

  always @(posedge ena_x) begin
    if (!joy_load) begin
      tstep    <= 1;
      joy_data <= stream_bit(1);
    end else begin
      tstep    <= tstep + 1;
      joy_data <= stream_bit(tstep + 1);
    end
  end

  task automatic wait_load();
    int n = 0;
    do begin
      @(posedge ena_x);
      n++;
    end while (joy_load && n < WAIT_TO);
    if (joy_load) begin
      $display("Timeout while waiting for the joystick load strobe");
      wait_errs++;
    end
  endtask

  task automatic wait_frame();
    int n = 0;
    do begin
      @(posedge ena_x);
      n++;
    end while (!uut.joy_valid && n < WAIT_TO);
    if (!uut.joy_valid) begin
      $display("Timeout while waiting for joy_valid");
      wait_errs++;
    end
  endtask

  task automatic wait_reset_low();
    int n = 0;
    do begin
      @(posedge ena_x);
      n++;
    end while (core_reset && n < WAIT_TO);
    if (core_reset) begin
      $display("Timeout while waiting for core_reset to fall");
      wait_errs++;
    end
  endtask

  task automatic send_joy(input logic [23:0] pat);
    wait_load();
    joy_pat <= pat;
    wait_frame();
  endtask

  // ----------------------------------------
  // PS/2 keyboard model
  // ----------------------------------------
  task automatic send_code(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge ena_x);
      ps2_data <= frame[i];
      repeat (4) @(posedge ena_x);
      ps2_clk <= 1'b0;
      repeat (4) @(posedge ena_x);
      ps2_clk <= 1'b1;
    end
    repeat (12) @(posedge ena_x);      // Gap between frames
  endtask

  task automatic release_key(input logic [7:0] code);
    send_code(arcade_ctrl_pkg::KEY_BREAK, 1'b0);
    send_code(code, 1'b0);
  endtask

  task automatic end_test(input string name);
    int fails;
    fails = uut.sva.fail_cnt + wait_errs;
    n_tests++;
    if (fails != last_fails) n_bad++;
    $display("Test %0d %s: %s", n_tests, name, (fails == last_fails) ? "ok" : "errors");
    last_fails = fails;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [23:0] pat;
    int          fails;
    seed = 91;
    pll_lckd     <= 1'b0;
    ps2_clk      <= 1'b1;
    ps2_data     <= 1'b1;
    btn          <= 2'b11;
    scandbl_ctrl <= 2'b00;
    joy_pat      <= '1;
    repeat (5) @(posedge ena_x);
    pll_lckd <= 1'b1;

    wait_frame();
    wait_frame();
    end_test("reset values and load strobe");

    for (int i = 0; i < 8; i++) begin
      pat = 24'($random(seed));
      pat[J1R] = 1'b1;
      pat[J2R] = 1'b1;
      btn <= (i % 3 == 0) ? 2'b10 : 2'b11;   // Coin button on some frames
      send_joy(pat);
    end
    btn <= 2'b11;
    send_joy('1);
    end_test("random joystick frames");

    pat = '1;
    pat[J1R] = 1'b0;
    send_joy(pat);
    send_joy('1);
    wait_reset_low();
    btn <= 2'b01;
    repeat (10) @(posedge ena_x);
    btn <= 2'b11;
    wait_reset_low();
    repeat (2) begin
      pat = '1;
      pat[J2R] = 1'b0;
      send_joy(pat);
      send_joy('1);
    end
    end_test("joystick and button reset, reboot");

    send_code(arcade_ctrl_pkg::KEY_RESET, 1'b0);
    repeat (20) @(posedge ena_x);
    release_key(arcade_ctrl_pkg::KEY_RESET);
    wait_reset_low();
    send_code(arcade_ctrl_pkg::KEY_EXT, 1'b0);       // Right Ctrl
    send_code(arcade_ctrl_pkg::KEY_CTRL, 1'b0);
    send_code(arcade_ctrl_pkg::KEY_ALT, 1'b0);
    send_code(arcade_ctrl_pkg::KEY_BKSP, 1'b0);
    release_key(arcade_ctrl_pkg::KEY_BKSP);
    release_key(arcade_ctrl_pkg::KEY_ALT);
    send_code(arcade_ctrl_pkg::KEY_EXT, 1'b0);
    release_key(arcade_ctrl_pkg::KEY_CTRL);
    end_test("reset key and master reset");

    send_code(arcade_ctrl_pkg::KEY_SCRL, 1'b0);
    send_code(arcade_ctrl_pkg::KEY_SCRL, 1'b0);      // Typematic repeat
    release_key(arcade_ctrl_pkg::KEY_SCRL);
    send_code(arcade_ctrl_pkg::KEY_VMODE, 1'b0);
    send_code(arcade_ctrl_pkg::KEY_VMODE, 1'b0);
    release_key(arcade_ctrl_pkg::KEY_VMODE);
    scandbl_ctrl <= 2'b01;
    repeat (4) @(posedge ena_x);
    send_code(arcade_ctrl_pkg::KEY_SCRL, 1'b1);      // Bad parity
    send_code(arcade_ctrl_pkg::KEY_VMODE, 1'b1);
    end_test("mode toggles and bad parity");

    fails = uut.sva.fail_cnt + wait_errs;
    $display("Tests: %0d, with errors: %0d, failed checks: %0d", n_tests, n_bad, fails);
    if (fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hw/arcade_ctrl_pkg.sv
hw/joy_serial_reader.sv
hw/ps2_receiver.sv
hw/key_mapper.sv
hw/panel_ctrl.sv
hw/arcade_ctrl_top.sv
sim/arcade_ctrl_sva.sv
sim/tb_arcade_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_arcade_ctrl -f all.f

# Keep running after a failed assertion so the summary is printed
out=$(./obj_dir/Vtb_arcade_ctrl +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "Result: PASSED"
